/* compositor.f */
verilog/vcomp_pkg.sv
verilog/video_stream_if.sv
verilog/layer_blender.sv
verilog/frame_monitor.sv
verilog/video_compositor.sv
dv/tb_video_compositor.sv

/* run_sim.sh */
#!/bin/sh
# Build the compositor testbench with Verilator and run it into sim.log

LOG=sim.log

verilator --binary --timing -Wno-fatal \
	--top-module tb_video_compositor \
	-f compositor.f \
	-o tb_video_compositor > "$LOG" 2>&1 &&
	./obj_dir/tb_video_compositor >> "$LOG" 2>&1 ||
	echo "CHECKS FAILED" >> "$LOG"

cat "$LOG"

# The log decides the result
grep -q "CHECKS FAILED" "$LOG" &&
	{ echo "Simulation failed, see $LOG"; exit 1; } ||
	{ echo "Simulation passed"; exit 0; }

/* dv/compositor_trace.txt */
# Test header: T num en0 en1 ready_mode mon_check width height beats0 beats1
# Beat line, hex: base user last layer0 layer1 expected (layer = alpha c2 c1 c0)
T 1 1 1 0 0 0 0 0 0
00 1 0 00000000 00000000 000000
01 0 0 00000000 00000000 000000
80 0 0 00000000 00000000 7e7e7e
ff 0 0 00000000 00000000 fdfdfd
40 0 1 00000000 00000000 3e3e3e
T 2 1 1 0 0 0 0 0 0
80 3 0 00112233 00000000 7e7e7e
80 2 0 ff102030 00000000 0e1e2e
40 2 0 80ff0080 00000000 9e1e5e
ff 0 1 00000000 00000000 fdfdfd
T 3 1 1 0 0 0 0 0 0
80 7 0 ff102030 00aabbcc 0e1e2e
80 4 0 00000000 ff405060 3f4f5f
40 6 1 80ff0080 80000000 4e0f2f
00 2 0 40ffffff 00000000 3e3e3e
c8 0 0 00000000 00000000 c6c6c6
20 4 1 00000000 40808080 373737
T 4 1 0 0 0 0 0 0 0
80 7 0 ff102030 00aabbcc 0e1e2e
80 4 0 00000000 ff405060 7e7e7e
40 6 1 80ff0080 80000000 9e1e5e
T 5 1 1 1 0 0 0 0 0
80 7 0 ff102030 00aabbcc 0e1e2e
80 4 0 00000000 ff405060 3f4f5f
40 6 1 80ff0080 80000000 4e0f2f
00 2 0 40ffffff 00000000 3e3e3e
c8 0 0 00000000 00000000 c6c6c6
20 4 1 00000000 40808080 373737
T 6 1 1 0 1 3 2 3 2
10 1 0 00000000 00000000 0e0e0e
20 4 0 00000000 ff010203 000102
30 4 1 00000000 00ffffff 2e2e2e
40 2 0 ff505050 00000000 4e4e4e
50 0 0 00000000 00000000 4e4e4e
60 0 1 00000000 00000000 5e5e5e
70 3 0 00123456 00000000 6e6e6e
80 4 0 00000000 ff112233 102132
90 4 1 00000000 00000000 8e8e8e
a0 2 0 ff0a0b0c 00000000 08090a
b0 2 0 00000000 00000000 aeaeae
c0 0 1 00000000 00000000 bebebe
d0 1 0 00000000 00000000 cecece

/* dv/tb_video_compositor.sv */
`timescale 1ns/1ps

module tb_video_compositor;
	import vcomp_pkg::*;

	localparam int MAX_BEATS = 64;
	localparam int MAX_TESTS = 8;

	logic                                   clk = 1'b0;
	logic                                   resetn = 1'b0;
	logic                                   base_valid = 1'b0;
	logic [7:0]                             base_data = '0;
	logic [2:0]                             base_user = '0;
	logic                                   base_last = 1'b0;
	logic                                   base_ready;
	logic                                   lay_vld [2];
	layer_pix_t                             lay_dat [2];
	logic [1:0]                             layer_enable = '0;
	logic [1:0]                             layer_ready;
	logic                                   out_valid;
	rgb_t                                   out_data;
	logic                                   out_sof;
	logic                                   out_last;
	logic                                   out_ready = 1'b1;
	logic [COUNT_WIDTH-1:0]                 frame_width;
	logic [COUNT_WIDTH-1:0]                 frame_height;
	logic [NUM_LAYERS-1:0][COUNT_WIDTH-1:0] layer_beats;

	// Trace contents
	logic [7:0]  b_data [MAX_BEATS];
	logic [2:0]  b_user [MAX_BEATS];
	logic        b_last [MAX_BEATS];
	logic [31:0] b_lay  [MAX_BEATS][2];
	logic [23:0] b_exp  [MAX_BEATS];
	int          t_num [MAX_TESTS];
	logic [1:0]  t_en [MAX_TESTS];
	int          t_mode [MAX_TESTS];
	int          t_mon [MAX_TESTS];
	int          t_width [MAX_TESTS];
	int          t_height [MAX_TESTS];
	int          t_beats [MAX_TESTS][2];
	int          t_first [MAX_TESTS];
	int          t_len [MAX_TESTS];

	int          n_tests = 0;
	int          n_beats = 0;
	int          err_cnt = 0;
	int          tests_failed = 0;
	logic        trace_loaded = 1'b0;
	logic        idle [2];
	int          ready_mode = 0;
	int          ready_mode_s;
	logic [31:0] seed = 32'hb9aa;

	video_compositor UUT (
		.clk         (clk),
		.resetn      (resetn),
		.base_valid  (base_valid),
		.base_data   (base_data),
		.base_user   (base_user),
		.base_last   (base_last),
		.base_ready  (base_ready),
		.layer_valid ({lay_vld[1], lay_vld[0]}),
		.layer_data  ({lay_dat[1], lay_dat[0]}),
		.layer_enable(layer_enable),
		.layer_ready (layer_ready),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.out_sof     (out_sof),
		.out_last    (out_last),
		.out_ready   (out_ready),
		.frame_width (frame_width),
		.frame_height(frame_height),
		.layer_beats (layer_beats)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	//////////////////////////////
	// Output ready pattern
	//////////////////////////////

	// Mode 1 pulls ready low about a third of the time
	always @(posedge clk) begin
		ready_mode_s = ready_mode;
		#1;
		if (ready_mode_s == 1) begin
			seed = lcg_next(seed);
			out_ready = (seed[31:16] % 3) != 0;
		end else begin
			out_ready = 1'b1;
		end
	end

	// An unused layer must never be read
	always @(posedge clk) begin
		for (int k = 0; k < 2; k++) begin
			if (idle[k] && layer_ready[k]) begin
				$display("Fail %0t layer_ready[%0d] rose while the layer was not needed",
					$time, k);
				err_cnt++;
			end
		end
	end

	task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		$display("Fail %0t %s expected %h got %h", $time, sig, exp_v, got_v);
		err_cnt++;
	endtask

	task automatic load_trace();
		int          fd;
		int          r;
		int          tn;
		int          e0;
		int          e1;
		int          md;
		int          mon;
		int          w;
		int          h;
		int          c0;
		int          c1;
		string       line;
		logic [31:0] v_base;
		logic [31:0] v_user;
		logic [31:0] v_last;
		logic [31:0] v_l0;
		logic [31:0] v_l1;
		logic [31:0] v_exp;
		fd = $fopen("dv/compositor_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file dv/compositor_trace.txt");
			err_cnt++;
			return;
		end
		while (!$feof(fd)) begin
			r = $fgets(line, fd);
			if (r == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			if (line.getc(0) == "T") begin
				r = $sscanf(line, "T %d %d %d %d %d %d %d %d %d",
					tn, e0, e1, md, mon, w, h, c0, c1);
				t_num[n_tests]    = tn;
				t_en[n_tests]     = {e1[0], e0[0]};
				t_mode[n_tests]   = md;
				t_mon[n_tests]    = mon;
				t_width[n_tests]  = w;
				t_height[n_tests] = h;
				t_beats[n_tests][0] = c0;
				t_beats[n_tests][1] = c1;
				t_first[n_tests]  = n_beats;
				t_len[n_tests]    = 0;
				n_tests++;
			end else if (n_tests > 0) begin
				r = $sscanf(line, "%h %h %h %h %h %h",
					v_base, v_user, v_last, v_l0, v_l1, v_exp);
				b_data[n_beats]    = v_base[7:0];
				b_user[n_beats]    = v_user[2:0];
				b_last[n_beats]    = v_last[0];
				b_lay[n_beats][0]  = v_l0;
				b_lay[n_beats][1]  = v_l1;
				b_exp[n_beats]     = v_exp[23:0];
				t_len[n_tests-1]++;
				n_beats++;
			end
		end
		$fclose(fd);
		if (n_tests == 0) begin
			$display("The trace file holds no tests");
			err_cnt++;
		end
	endtask

	//////////////////////////////
	// Drivers and collector
	//////////////////////////////

	task automatic drive_base(input int t);
		int i;
		for (i = t_first[t]; i < t_first[t] + t_len[t]; i++) begin
			base_valid = 1'b1;
			base_data  = b_data[i];
			base_user  = b_user[i];
			base_last  = b_last[i];
			@(posedge clk);
			while (!base_ready)
				@(posedge clk);
			#1;
		end
		base_valid = 1'b0;
	endtask

	task automatic drive_layer(input int k, input int t);
		int i;
		int wanted;
		wanted = 0;
		for (i = t_first[t]; i < t_first[t] + t_len[t]; i++) begin
			if (b_user[i][k+1] && t_en[t][k])
				wanted++;
		end
		// Full-alpha white would show up in every pixel if it were mixed
		if (wanted == 0) begin
			idle[k]    = 1'b1;
			lay_vld[k] = 1'b1;
			lay_dat[k] = 32'hffffffff;
			return;
		end
		for (i = t_first[t]; i < t_first[t] + t_len[t]; i++) begin
			if (b_user[i][k+1] && t_en[t][k]) begin
				lay_vld[k] = 1'b1;
				lay_dat[k] = b_lay[i][k];
				@(posedge clk);
				while (!layer_ready[k])
					@(posedge clk);
				#1;
			end
		end
		lay_vld[k] = 1'b0;
	endtask

	task automatic collect(input int t);
		int i;
		for (i = t_first[t]; i < t_first[t] + t_len[t]; i++) begin
			@(posedge clk);
			while (!(out_valid && out_ready))
				@(posedge clk);
			if (out_data !== b_exp[i])
				report_mismatch("out_data", b_exp[i], out_data);
			if (out_sof !== b_user[i][0])
				report_mismatch("out_sof", b_user[i][0], out_sof);
			if (out_last !== b_last[i])
				report_mismatch("out_last", b_last[i], out_last);
		end
	endtask

	task automatic run_test(input int t);
		int errs_at_start;
		errs_at_start = err_cnt;
		layer_enable  = t_en[t];
		ready_mode    = t_mode[t];
		fork
			drive_base(t);
			drive_layer(0, t);
			drive_layer(1, t);
			collect(t);
		join
		#1;
		ready_mode = 0;
		lay_vld[0] = 1'b0;
		lay_vld[1] = 1'b0;
		idle[0]    = 1'b0;
		idle[1]    = 1'b0;
		// Pipeline is empty, so any further beat is a duplicate
		repeat (8) begin
			@(posedge clk);
			if (out_valid)
				$display("Fail %0t extra output beat after test %0d", $time, t_num[t]);
			if (out_valid)
				err_cnt++;
		end
		#1;
		if (t_mon[t] != 0) begin
			if (frame_width !== t_width[t])
				report_mismatch("frame_width", t_width[t], frame_width);
			if (frame_height !== t_height[t])
				report_mismatch("frame_height", t_height[t], frame_height);
			if (layer_beats[0] !== t_beats[t][0])
				report_mismatch("layer_beats[0]", t_beats[t][0], layer_beats[0]);
			if (layer_beats[1] !== t_beats[t][1])
				report_mismatch("layer_beats[1]", t_beats[t][1], layer_beats[1]);
		end
		if (err_cnt == errs_at_start) begin
			$display("pass test %0d", t_num[t]);
		end else begin
			$display("Fail test %0d, %0d errors", t_num[t], err_cnt - errs_at_start);
			tests_failed++;
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int t;
		lay_vld[0] = 1'b0;
		lay_vld[1] = 1'b0;
		lay_dat[0] = '0;
		lay_dat[1] = '0;
		idle[0]    = 1'b0;
		idle[1]    = 1'b0;
		load_trace();
		trace_loaded = 1'b1;
		repeat (8) @(posedge clk);
		if (out_valid !== 1'b0)
			report_mismatch("out_valid", 0, out_valid);
		if (base_ready !== 1'b0)
			report_mismatch("base_ready", 0, base_ready);
		if (layer_ready !== 2'b00)
			report_mismatch("layer_ready", 0, layer_ready);
		if (frame_width !== '0)
			report_mismatch("frame_width", 0, frame_width);
		if (frame_height !== '0)
			report_mismatch("frame_height", 0, frame_height);
		if (layer_beats !== '0)
			report_mismatch("layer_beats", 0, layer_beats);
		#1;
		resetn = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		for (t = 0; t < n_tests; t++)
			run_test(t);
		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			n_tests, n_tests - tests_failed, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog scaled to the trace length
	initial begin
		wait (trace_loaded);
		#(40 * n_beats + 400);
		$display("Timeout: the run did not finish within %0d ns", 40 * n_beats + 400);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* verilog/video_compositor.sv */
`timescale 1ns/1ps

module video_compositor (
	input  logic                                   clk,
	input  logic                                   resetn,

	// Gray base stream
	input  logic                                   base_valid,
	input  logic [vcomp_pkg::CHN_WIDTH-1:0]        base_data,
	input  logic [vcomp_pkg::NUM_LAYERS:0]         base_user,
	input  logic                                   base_last,
	output logic                                   base_ready,

	// Overlay layers
	input  logic [vcomp_pkg::NUM_LAYERS-1:0]       layer_valid,
	input  vcomp_pkg::layer_pix_t [vcomp_pkg::NUM_LAYERS-1:0] layer_data,
	input  logic [vcomp_pkg::NUM_LAYERS-1:0]       layer_enable,
	output logic [vcomp_pkg::NUM_LAYERS-1:0]       layer_ready,

	// Composited output
	output logic                                   out_valid,
	output vcomp_pkg::rgb_t                        out_data,
	output logic                                   out_sof,
	output logic                                   out_last,
	input  logic                                   out_ready,

	// Frame statistics
	output logic [vcomp_pkg::COUNT_WIDTH-1:0]      frame_width,
	output logic [vcomp_pkg::COUNT_WIDTH-1:0]      frame_height,
	output logic [vcomp_pkg::NUM_LAYERS-1:0][vcomp_pkg::COUNT_WIDTH-1:0] layer_beats
);
	import vcomp_pkg::*;

	localparam int RGB_W = CHN_WIDTH * OUT_CHN;

	video_stream_if #(.DATA_WIDTH(CHN_WIDTH), .USER_WIDTH(NUM_LAYERS + 1)) base_if ();
	video_stream_if #(.DATA_WIDTH(RGB_W), .USER_WIDTH(NUM_LAYERS)) mid_if ();
	video_stream_if #(.DATA_WIDTH(RGB_W), .USER_WIDTH(NUM_LAYERS - 1)) out_if ();

	logic                  base_fire;
	logic [NUM_LAYERS-1:0] layer_fire;

	//////////////////////////////
	// Stream wrapping
	//////////////////////////////

	assign base_if.valid = base_valid;
	assign base_if.data  = base_data;
	assign base_if.user  = base_user;
	assign base_if.last  = base_last;
	assign base_ready    = base_if.ready;

	assign out_valid    = out_if.valid;
	assign out_data     = out_if.data;
	assign out_sof      = out_if.user[0];
	assign out_last     = out_if.last;
	assign out_if.ready = out_ready;

	//////////////////////////////
	// Blend cascade
	//////////////////////////////

	// Gray in, layer 0 over it
	layer_blender #(
		.BASE_CHN  (1),
		.NEED_WIDTH(NUM_LAYERS + 1)
	) u_blend0 (
		.clk         (clk),
		.resetn      (resetn),
		.base        (base_if.sink),
		.layer_valid (layer_valid[0]),
		.layer_data  (layer_data[0]),
		.layer_enable(layer_enable[0]),
		.layer_ready (layer_ready[0]),
		.out         (mid_if.source)
	);

	// Layer 1 on top
	layer_blender #(
		.BASE_CHN  (OUT_CHN),
		.NEED_WIDTH(NUM_LAYERS)
	) u_blend1 (
		.clk         (clk),
		.resetn      (resetn),
		.base        (mid_if.sink),
		.layer_valid (layer_valid[1]),
		.layer_data  (layer_data[1]),
		.layer_enable(layer_enable[1]),
		.layer_ready (layer_ready[1]),
		.out         (out_if.source)
	);

	//////////////////////////////
	// Frame statistics
	//////////////////////////////

	assign base_fire  = base_valid & base_ready;
	assign layer_fire = layer_valid & layer_ready;

	frame_monitor u_monitor (
		.clk         (clk),
		.resetn      (resetn),
		.base_fire   (base_fire),
		.base_sof    (base_user[0]),
		.base_last   (base_last),
		.layer_fire  (layer_fire),
		.frame_width (frame_width),
		.frame_height(frame_height),
		.layer_beats (layer_beats)
	);

endmodule

/* verilog/frame_monitor.sv */
`timescale 1ns/1ps

module frame_monitor (
	input  logic                                   clk,
	input  logic                                   resetn,
	input  logic                                   base_fire,
	input  logic                                   base_sof,
	input  logic                                   base_last,
	input  logic [vcomp_pkg::NUM_LAYERS-1:0]       layer_fire,
	output logic [vcomp_pkg::COUNT_WIDTH-1:0]      frame_width,
	output logic [vcomp_pkg::COUNT_WIDTH-1:0]      frame_height,
	output logic [vcomp_pkg::NUM_LAYERS-1:0][vcomp_pkg::COUNT_WIDTH-1:0] layer_beats
);
	import vcomp_pkg::*;

	logic [COUNT_WIDTH-1:0]                 col_cnt;
	logic [COUNT_WIDTH-1:0]                 line_cnt;
	logic [NUM_LAYERS-1:0][COUNT_WIDTH-1:0] beat_cnt;
	logic                                   sof_fire;

	assign sof_fire = base_fire & base_sof;

	//////////////////////////////
	// Line geometry
	//////////////////////////////

	// Width is taken at every line end
	always_ff @(posedge clk) begin
		if (resetn == 1'b0) begin
			col_cnt     <= '0;
			frame_width <= '0;
		end else if (base_fire) begin
			if (base_last) begin
				col_cnt     <= '0;
				frame_width <= col_cnt + COUNT_WIDTH'(1);
			end else begin
				col_cnt <= col_cnt + COUNT_WIDTH'(1);
			end
		end
	end

	// Start beat closes the old frame and counts toward the new one
	always_ff @(posedge clk) begin
		if (resetn == 1'b0) begin
			line_cnt     <= '0;
			frame_height <= '0;
		end else if (sof_fire) begin
			frame_height <= line_cnt;
			line_cnt     <= base_last ? COUNT_WIDTH'(1) : '0;
		end else if (base_fire && base_last) begin
			line_cnt <= line_cnt + COUNT_WIDTH'(1);
		end
	end

	//////////////////////////////
	// Layer beats per frame
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (resetn == 1'b0) begin
			beat_cnt    <= '0;
			layer_beats <= '0;
		end else begin
			for (int k = 0; k < NUM_LAYERS; k++) begin
				if (sof_fire) begin
					layer_beats[k] <= beat_cnt[k];
					beat_cnt[k]    <= layer_fire[k] ? COUNT_WIDTH'(1) : '0;
				end else if (layer_fire[k]) begin
					beat_cnt[k] <= beat_cnt[k] + COUNT_WIDTH'(1);
				end
			end
		end
	end

endmodule

/* verilog/layer_blender.sv */
`timescale 1ns/1ps

module layer_blender #(
	parameter int BASE_CHN   = 1,
	parameter int NEED_WIDTH = 3
) (
	input  logic                  clk,
	input  logic                  resetn,
	video_stream_if.sink          base,
	input  logic                  layer_valid,
	input  vcomp_pkg::layer_pix_t layer_data,
	input  logic                  layer_enable,
	output logic                  layer_ready,
	video_stream_if.source        out
);
	import vcomp_pkg::*;

	localparam int DELAY    = 3;
	localparam int PROD_W   = CHN_WIDTH + ALPHA_WIDTH;
	localparam int OUT_USER = NEED_WIDTH - 1;

	logic adv;
	logic need;
	logic in_valid;

	logic [DELAY-1:0]                vld_q;
	logic [DELAY-1:0]                last_q;
	logic [DELAY-1:0][OUT_USER-1:0]  user_q;
	logic [OUT_USER-1:0]             user_in;

	logic [BASE_CHN-1:0][CHN_WIDTH-1:0] base_d0;
	logic [ALPHA_WIDTH-1:0]             nalpha_d0;
	logic [OUT_CHN-1:0][PROD_W-1:0]     lay_mul_d0;
	logic [BASE_CHN-1:0][PROD_W-1:0]    base_mul_d1;
	logic [OUT_CHN-1:0][PROD_W-1:0]     lay_mul_d1;
	rgb_t                               mix_d2;

	//////////////////////////////
	// Handshake
	//////////////////////////////

	// Pipeline moves when the output slot is free or being drained
	assign adv      = ~out.valid | out.ready;
	assign need     = base.user[1] & layer_enable;
	assign in_valid = base.valid & (~need | layer_valid);

	assign base.ready  = adv & in_valid;
	assign layer_ready = adv & base.valid & layer_valid & need;

	//////////////////////////////
	// Control chain
	//////////////////////////////

	// Keep start of frame, drop the consumed need bit
	assign user_in[0] = base.user[0];

	generate
		if (NEED_WIDTH > 2) begin : g_user_shift
			assign user_in[OUT_USER-1:1] = base.user[NEED_WIDTH-1:2];
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (resetn == 1'b0) begin
			vld_q  <= '0;
			last_q <= '0;
			user_q <= '0;
		end else if (adv) begin
			vld_q  <= {vld_q[DELAY-2:0], in_valid};
			last_q <= {last_q[DELAY-2:0], base.last};
			user_q <= {user_q[DELAY-2:0], user_in};
		end
	end

	assign out.valid = vld_q[DELAY-1];
	assign out.last  = last_q[DELAY-1];
	assign out.user  = user_q[DELAY-1];

	//////////////////////////////
	// Blend data path
	//////////////////////////////

	// Step 1: latch base, inverted alpha
	always_ff @(posedge clk) begin
		if (adv) begin
			base_d0 <= base.data;
			if (need)
				nalpha_d0 <= ~layer_data.alpha;
			else
				nalpha_d0 <= '1;
		end
	end

	genvar c;

	// Layer product, zero when the layer is not mixed
	for (c = 0; c < OUT_CHN; c++) begin : g_layer
		always_ff @(posedge clk) begin
			if (adv) begin
				if (need)
					lay_mul_d0[c] <= PROD_W'(layer_data.color[c]) * PROD_W'(layer_data.alpha);
				else
					lay_mul_d0[c] <= '0;
				lay_mul_d1[c] <= lay_mul_d0[c];
			end
		end
	end

	// Step 2: base times inverted alpha
	for (c = 0; c < BASE_CHN; c++) begin : g_base
		always_ff @(posedge clk) begin
			if (adv)
				base_mul_d1[c] <= PROD_W'(base_d0[c]) * PROD_W'(nalpha_d0);
		end
	end

	// Step 3: sum and keep the top byte, gray fans out to all channels
	for (c = 0; c < OUT_CHN; c++) begin : g_mix
		localparam int BI = (BASE_CHN == 1) ? 0 : c;
		logic [PROD_W-1:0] sum;

		assign sum = base_mul_d1[BI] + lay_mul_d1[c];

		always_ff @(posedge clk) begin
			if (adv)
				mix_d2[c] <= sum[PROD_W-1:ALPHA_WIDTH];
		end
	end

	assign out.data = mix_d2;

endmodule

/* verilog/video_stream_if.sv */
`timescale 1ns/1ps

interface video_stream_if #(
	parameter int DATA_WIDTH = 24,
	parameter int USER_WIDTH = 1
);
	logic                  valid;
	logic [DATA_WIDTH-1:0] data;
	logic [USER_WIDTH-1:0] user;
	logic                  last;
	logic                  ready;

	// Producer side
	modport source (
		output valid,
		output data,
		output user,
		output last,
		input  ready
	);

	// Consumer side
	modport sink (
		input  valid,
		input  data,
		input  user,
		input  last,
		output ready
	);

endinterface

/* verilog/vcomp_pkg.sv */
package vcomp_pkg;

	// Channel and alpha widths
	localparam int CHN_WIDTH   = 8;
	localparam int ALPHA_WIDTH = 8;

	// Composited pixel is RGB
	localparam int OUT_CHN = 3;

	// User bit 0 is start of frame, bit k+1 marks layer k as needed
	localparam int NUM_LAYERS = 2;

	// Monitor counters
	localparam int COUNT_WIDTH = 12;

	// Channel 0 sits in the low byte
	typedef logic [OUT_CHN-1:0][CHN_WIDTH-1:0] rgb_t;

	// Colour low, alpha on top
	typedef struct packed {
		logic [ALPHA_WIDTH-1:0] alpha;
		rgb_t                   color;
	} layer_pix_t;

endpackage
